// File: source/boot_mem_pkg.sv
// Boot RAM shared types; byte addresses cover 64 KB and the port word is fixed at 64 bits
package boot_mem_pkg;

   ////////////////////////////////////////
   // Port geometry

   localparam int WORD_BITS = 64;             // Port data width
   localparam int STRB_BITS = WORD_BITS / 8;  // One enable per byte
   localparam int ADDR_BITS = 16;             // 2^16 -> 64 KB

   ////////////////////////////////////////
   // Reset vectors selected by the DIP switches

   localparam logic [31:0] VEC_SEL0 = 32'h4000_0000;  // Boot RAM
   localparam logic [31:0] VEC_SEL1 = 32'h8000_0000;  // DRAM base
   localparam logic [31:0] VEC_SEL2 = 32'h8020_0000;

   ////////////////////////////////////////
   // Request encoding

   typedef enum logic
   {
      OP_READ  = 1'b0,
      OP_WRITE = 1'b1
   } mem_op_e;

   // Requesters sharing the RAM
   typedef enum logic
   {
      OWNER_CORE = 1'b0,
      OWNER_HOST = 1'b1
   } owner_e;

   // 89 bits in total
   typedef struct packed
   {
      mem_op_e              op;
      logic [ADDR_BITS-1:0] addr;   // Byte address
      logic [STRB_BITS-1:0] wstrb;  // Ignored on reads
      logic [WORD_BITS-1:0] wdata;
   } mem_req_t;

endpackage

// File: source/req_slot.sv
// Holds one request per port; the port must wait for its response before strobing again
`timescale 1ns/1ps

module req_slot import boot_mem_pkg::*;
(
   input  logic     ram_clk,
   input  logic     arst_n_i,
   input  logic     req_valid_i,  // Single-cycle strobe
   input  mem_req_t req_i,
   input  logic     grant_i,
   output logic     pending_o,
   output mem_req_t held_o
);

   logic     pending_q;
   mem_req_t held_q;

   // A new strobe takes precedence over a grant
   always_ff @(posedge ram_clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
         pending_q <= 1'b0;
      else if (req_valid_i)
         pending_q <= 1'b1;
      else if (grant_i)
         pending_q <= 1'b0;  // Access issued to RAM
   end

   // Payload only
   always_ff @(posedge ram_clk)
   begin
      if (req_valid_i)
         held_q <= req_i;
   end

   assign pending_o = pending_q;
   assign held_o    = held_q;

endmodule

// File: source/bram_arbiter.sv
// Round-robin between core and host slots; one access per cycle, response one cycle after it
`timescale 1ns/1ps

module bram_arbiter import boot_mem_pkg::*;
(
   input  logic                 ram_clk,
   input  logic                 arst_n_i,
   input  logic                 core_pending_i,
   input  logic                 host_pending_i,
   input  mem_req_t             core_req_i,
   input  mem_req_t             host_req_i,
   output logic                 core_grant_o,
   output logic                 host_grant_o,
   output logic                 ram_en_o,
   output mem_req_t             ram_req_o,
   input  logic [WORD_BITS-1:0] ram_rdata_i,
   output logic                 core_rsp_valid_o,
   output logic                 host_rsp_valid_o,
   output logic [WORD_BITS-1:0] rsp_rdata_o
);

   owner_e owner_q;     // Last granted requester
   logic   rsp_v_q;     // RAM acted at the last edge
   logic   core_win;

   ////////////////////////////////////////
   // Grant

   // Core wins when alone, or when host had the last turn
   assign core_win = core_pending_i & (~host_pending_i | (owner_q == OWNER_HOST));

   assign core_grant_o = core_win;
   assign host_grant_o = host_pending_i & ~core_win;

   assign ram_en_o  = core_pending_i | host_pending_i;
   assign ram_req_o = core_win ? core_req_i : host_req_i;

   ////////////////////////////////////////
   // Response routing

   always_ff @(posedge ram_clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         owner_q <= OWNER_HOST;  // Core first after reset
         rsp_v_q <= 1'b0;
      end
      else
      begin
         rsp_v_q <= ram_en_o;
         if (ram_en_o)
            owner_q <= core_win ? OWNER_CORE : OWNER_HOST;
      end
   end

   assign core_rsp_valid_o = rsp_v_q & (owner_q == OWNER_CORE);
   assign host_rsp_valid_o = rsp_v_q & (owner_q == OWNER_HOST);

   // Shared, only the strobed owner samples it
   assign rsp_rdata_o = ram_rdata_i;

endmodule

// File: source/wide_bram.sv
// Line-wide RAM with 64-bit word access; LINE_BITS must be a power-of-two multiple of 128 or more
`timescale 1ns/1ps

module wide_bram import boot_mem_pkg::*;
#(
   parameter int LINE_BITS = 128
)
(
   input  logic                 ram_clk,
   input  logic                 arst_n_i,
   input  logic                 en_i,
   input  mem_req_t             req_i,
   output logic [WORD_BITS-1:0] rdata_o
);

   ////////////////////////////////////////
   // Address split

   localparam int LINE_BYTES    = LINE_BITS / 8;
   localparam int WORDS         = LINE_BITS / WORD_BITS;       // Words per line
   localparam int OFFSET_BITS   = $clog2(STRB_BITS);           // Byte within word
   localparam int WSEL_BITS     = $clog2(WORDS);               // Word within line
   localparam int LINE_IDX_BITS = ADDR_BITS - WSEL_BITS - OFFSET_BITS;
   localparam int DEPTH         = 2 ** LINE_IDX_BITS;

   logic [LINE_BITS-1:0]     mem [DEPTH];

   logic [LINE_IDX_BITS-1:0] line_idx;
   logic [WSEL_BITS-1:0]     word_sel;
   logic [LINE_IDX_BITS-1:0] line_idx_q;
   logic [WSEL_BITS-1:0]     word_sel_q;

   logic [LINE_BYTES-1:0]    we_full;
   logic [LINE_BITS-1:0]     wdata_full;
   logic [LINE_BITS-1:0]     rd_line;
   logic                     wr_en;

   assign line_idx = req_i.addr[ADDR_BITS-1 -: LINE_IDX_BITS];
   assign word_sel = req_i.addr[OFFSET_BITS +: WSEL_BITS];

   ////////////////////////////////////////
   // Write path

   assign wr_en = en_i & (req_i.op == OP_WRITE);

   // Same word on every lane, enables pick the addressed one
   assign wdata_full = {WORDS{req_i.wdata}};

   always_comb
   begin
      we_full = '0;
      we_full[STRB_BITS-1:0] = req_i.wstrb;
      we_full = we_full << (word_sel * STRB_BITS);
   end

   // Byte-masked update, no reset on the array
   always_ff @(posedge ram_clk)
   begin
      if (wr_en)
      begin
         for (int b = 0; b < LINE_BYTES; b++)
         begin
            if (we_full[b])
               mem[line_idx][b*8 +: 8] <= wdata_full[b*8 +: 8];
         end
      end
   end

   ////////////////////////////////////////
   // Read path

   // Address registered on every access
   always_ff @(posedge ram_clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         line_idx_q <= '0;
         word_sel_q <= '0;
      end
      else if (en_i)
      begin
         line_idx_q <= line_idx;
         word_sel_q <= word_sel;
      end
   end

   assign rd_line = mem[line_idx_q];
   assign rdata_o = rd_line[word_sel_q*WORD_BITS +: WORD_BITS];  // Addressed word out

endmodule

// File: source/boot_mem_top.sv
// Boot RAM with core and host ports; each port keeps at most one request in flight
`timescale 1ns/1ps

module boot_mem_top import boot_mem_pkg::*;
#(
   parameter int LINE_BITS = 128  // 128 or 256
)
(
   input  logic                 ram_clk,
   input  logic                 arst_n_i,
   input  logic                 core_req_valid_i,
   input  mem_req_t             core_req_i,
   input  logic                 host_req_valid_i,
   input  mem_req_t             host_req_i,
   output logic                 core_rsp_valid_o,
   output logic                 host_rsp_valid_o,
   output logic [WORD_BITS-1:0] rsp_rdata_o,
   input  logic [1:0]           boot_sel_i,
   output logic [31:0]          reset_vector_o
);

   logic                 core_pending, host_pending;
   logic                 core_grant, host_grant;
   mem_req_t             core_held, host_held;
   logic                 ram_en;
   mem_req_t             ram_req;
   logic [WORD_BITS-1:0] ram_rdata;

   ////////////////////////////////////////
   // Request slots

   req_slot u_core_slot
   (
      .ram_clk     ( ram_clk          ),
      .arst_n_i    ( arst_n_i         ),
      .req_valid_i ( core_req_valid_i ),
      .req_i       ( core_req_i       ),
      .grant_i     ( core_grant       ),
      .pending_o   ( core_pending     ),
      .held_o      ( core_held        )
   );

   req_slot u_host_slot
   (
      .ram_clk     ( ram_clk          ),
      .arst_n_i    ( arst_n_i         ),
      .req_valid_i ( host_req_valid_i ),
      .req_i       ( host_req_i       ),
      .grant_i     ( host_grant       ),
      .pending_o   ( host_pending     ),
      .held_o      ( host_held        )
   );

   ////////////////////////////////////////
   // Arbiter and RAM

   bram_arbiter u_arb
   (
      .ram_clk          ( ram_clk          ),
      .arst_n_i         ( arst_n_i         ),
      .core_pending_i   ( core_pending     ),
      .host_pending_i   ( host_pending     ),
      .core_req_i       ( core_held        ),
      .host_req_i       ( host_held        ),
      .core_grant_o     ( core_grant       ),
      .host_grant_o     ( host_grant       ),
      .ram_en_o         ( ram_en           ),
      .ram_req_o        ( ram_req          ),
      .ram_rdata_i      ( ram_rdata        ),
      .core_rsp_valid_o ( core_rsp_valid_o ),
      .host_rsp_valid_o ( host_rsp_valid_o ),
      .rsp_rdata_o      ( rsp_rdata_o      )
   );

   wide_bram #(.LINE_BITS(LINE_BITS)) u_ram
   (
      .ram_clk  ( ram_clk   ),
      .arst_n_i ( arst_n_i  ),
      .en_i     ( ram_en    ),
      .req_i    ( ram_req   ),
      .rdata_o  ( ram_rdata )
   );

   // Reset vector from the DIP switches
   always_comb
   begin
      casez (boot_sel_i)
         2'b01:   reset_vector_o = VEC_SEL1;
         2'b11:   reset_vector_o = VEC_SEL2;
         default: reset_vector_o = VEC_SEL0;  // Bit 0 low
      endcase
   end

endmodule

// File: tb/tb_boot_mem_top.sv
// Runs boot_mem_top at LINE_BITS 128; word-aligned addresses only, unwritten bytes unchecked
`timescale 1ns/1ps

module tb_boot_mem_top import boot_mem_pkg::*; ();

   localparam int TIMEOUT = 20;  // Edges allowed per response

   logic                 ram_clk;
   logic                 arst_n_i;
   logic                 core_req_valid_i;
   logic                 host_req_valid_i;
   mem_req_t             core_req_i;
   mem_req_t             host_req_i;
   logic                 core_rsp_valid_o;
   logic                 host_rsp_valid_o;
   logic [WORD_BITS-1:0] rsp_rdata_o;
   logic [1:0]           boot_sel_i;
   logic [31:0]          reset_vector_o;

   logic [7:0] model [0:(1<<ADDR_BITS)-1];    // Reference byte image
   bit         written [0:(1<<ADDR_BITS)-1];
   int         errors;
   int         timeouts;
   integer     seed;

   boot_mem_top #(.LINE_BITS(128)) dut
   (
      .ram_clk          ( ram_clk          ),
      .arst_n_i         ( arst_n_i         ),
      .core_req_valid_i ( core_req_valid_i ),
      .core_req_i       ( core_req_i       ),
      .host_req_valid_i ( host_req_valid_i ),
      .host_req_i       ( host_req_i       ),
      .core_rsp_valid_o ( core_rsp_valid_o ),
      .host_rsp_valid_o ( host_rsp_valid_o ),
      .rsp_rdata_o      ( rsp_rdata_o      ),
      .boot_sel_i       ( boot_sel_i       ),
      .reset_vector_o   ( reset_vector_o   )
   );

   initial
   begin
      ram_clk = 1'b0;
      forever #20 ram_clk = ~ram_clk;
   end

   ////////////////////////////////////////
   // Request helpers and reference model

   function automatic mem_req_t make_req(input mem_op_e op, input logic [ADDR_BITS-1:0] addr,
                                         input logic [STRB_BITS-1:0] strb,
                                         input logic [WORD_BITS-1:0] data);
      mem_req_t r;
      r.op    = op;
      r.addr  = addr;
      r.wstrb = strb;
      r.wdata = data;
      return r;
   endfunction

   // Host and core kept in separate halves
   function automatic mem_req_t rand_req(input owner_e port);
      logic [31:0]          r0;
      logic [31:0]          r1;
      logic [31:0]          r2;
      logic [31:0]          r3;
      logic [ADDR_BITS-1:0] addr;
      r0 = $random(seed);
      r1 = $random(seed);
      r2 = $random(seed);
      r3 = $random(seed);
      addr        = '0;
      addr[15]    = (port == OWNER_HOST);
      addr[14:12] = r0[2:0];
      addr[5:3]   = r0[5:3];
      return make_req(r0[8] ? OP_WRITE : OP_READ, addr, r1[7:0], {r2, r3});
   endfunction

   function automatic logic rsp_of(input owner_e port);
      return (port == OWNER_CORE) ? core_rsp_valid_o : host_rsp_valid_o;
   endfunction

   task automatic model_write(input mem_req_t req);
      int base;
      base = int'({req.addr[ADDR_BITS-1:3], 3'b000});
      for (int b = 0; b < STRB_BITS; b++)
      begin
         if (req.wstrb[b])
         begin
            model[base + b]   = req.wdata[b*8 +: 8];
            written[base + b] = 1'b1;
         end
      end
   endtask

   task automatic check_read(input string name, input logic [ADDR_BITS-1:0] addr,
                             input logic [WORD_BITS-1:0] got);
      int                   base;
      logic [WORD_BITS-1:0] expected;
      logic [WORD_BITS-1:0] mask;
      base     = int'({addr[ADDR_BITS-1:3], 3'b000});
      expected = '0;
      mask     = '0;
      for (int b = 0; b < STRB_BITS; b++)
      begin
         if (written[base + b])
         begin
            expected[b*8 +: 8] = model[base + b];
            mask[b*8 +: 8]     = 8'hff;
         end
      end
      if (mask != '0)
      begin
         assert ((got & mask) == (expected & mask))
         else
         begin
            errors++;
            $display("ERROR t=%0t %s rsp_rdata_o @%h got %h expected %h", $time, name, addr,
                     got & mask, expected & mask);
         end
      end
   endtask

   // One strobe, then wait for this port's response
   task automatic port_access(input owner_e port, input mem_req_t req);
      int    edges;
      bit    seen;
      string name;
      name = (port == OWNER_CORE) ? "core" : "host";
      @(posedge ram_clk);
      if (port == OWNER_CORE)
      begin
         core_req_valid_i <= 1'b1;
         core_req_i       <= req;
      end
      else
      begin
         host_req_valid_i <= 1'b1;
         host_req_i       <= req;
      end
      @(posedge ram_clk);
      if (port == OWNER_CORE)
         core_req_valid_i <= 1'b0;
      else
         host_req_valid_i <= 1'b0;
      edges = 1;
      @(negedge ram_clk);
      seen = rsp_of(port);
      while (!seen && edges < TIMEOUT)
      begin
         @(negedge ram_clk);
         edges++;
         seen = rsp_of(port);
      end
      if (!seen)
      begin
         timeouts++;
         $display("Timeout: no %s response within %0d clock edges", name, TIMEOUT);
      end
      else
      begin
         assert (edges <= 3)
         else
         begin
            errors++;
            $display("ERROR t=%0t %s_rsp_valid_o latency got %0d expected <= 3", $time, name,
                     edges);
         end
         if (req.op == OP_READ)
            check_read(name, req.addr, rsp_rdata_o);
         else
            model_write(req);
      end
   endtask

   ////////////////////////////////////////
   // Directed tests

   task automatic reset_state_test();
      logic [1:0]  sel_list [4];
      logic [31:0] expected;
      sel_list = '{2'b00, 2'b10, 2'b01, 2'b11};
      @(negedge ram_clk);
      assert (core_rsp_valid_o == 1'b0)
      else
      begin
         errors++;
         $display("ERROR t=%0t core_rsp_valid_o got %b expected 0", $time, core_rsp_valid_o);
      end
      assert (host_rsp_valid_o == 1'b0)
      else
      begin
         errors++;
         $display("ERROR t=%0t host_rsp_valid_o got %b expected 0", $time, host_rsp_valid_o);
      end
      foreach (sel_list[i])
      begin
         @(posedge ram_clk);
         boot_sel_i <= sel_list[i];
         @(negedge ram_clk);
         if (!sel_list[i][0])
            expected = VEC_SEL0;
         else if (!sel_list[i][1])
            expected = VEC_SEL1;
         else
            expected = VEC_SEL2;
         assert (reset_vector_o == expected)
         else
         begin
            errors++;
            $display("ERROR t=%0t reset_vector_o got %h expected %h", $time, reset_vector_o,
                     expected);
         end
      end
   endtask

   task automatic merge_and_lane_test();
      port_access(OWNER_CORE, make_req(OP_WRITE, 16'h0100, 8'hff, 64'h0123_4567_89ab_cdef));
      port_access(OWNER_CORE, make_req(OP_READ, 16'h0100, 8'h00, '0));
      port_access(OWNER_CORE, make_req(OP_WRITE, 16'h0200, 8'hff, 64'h1111_2222_3333_4444));
      port_access(OWNER_CORE, make_req(OP_WRITE, 16'h0200, 8'ha5, 64'haaaa_bbbb_cccc_dddd));
      port_access(OWNER_CORE, make_req(OP_READ, 16'h0200, 8'h00, '0));
      // Both words of one line
      port_access(OWNER_CORE, make_req(OP_WRITE, 16'h0300, 8'hff, 64'h5a5a_0000_1234_0300));
      port_access(OWNER_CORE, make_req(OP_WRITE, 16'h0308, 8'hff, 64'hc3c3_ffff_8765_0308));
      port_access(OWNER_CORE, make_req(OP_READ, 16'h0300, 8'h00, '0));
      port_access(OWNER_CORE, make_req(OP_READ, 16'h0308, 8'h00, '0));
   endtask

   task automatic count_pulses(output int core_n, output int host_n);
      core_n = 0;
      host_n = 0;
      for (int k = 0; k < 8; k++)
      begin
         @(negedge ram_clk);
         core_n += int'(core_rsp_valid_o);
         host_n += int'(host_rsp_valid_o);
      end
   endtask

   task automatic cross_port_test();
      int core_n;
      int host_n;
      port_access(OWNER_HOST, make_req(OP_WRITE, 16'h0400, 8'hff, 64'hfeed_face_cafe_0400));
      port_access(OWNER_CORE, make_req(OP_READ, 16'h0400, 8'h00, '0));
      fork
         port_access(OWNER_CORE, make_req(OP_READ, 16'h0308, 8'h00, '0));
         port_access(OWNER_HOST, make_req(OP_WRITE, 16'h0500, 8'hff, 64'h0bad_beef_0000_0500));
         count_pulses(core_n, host_n);
      join
      assert (core_n == 1)
      else
      begin
         errors++;
         $display("ERROR t=%0t core_rsp_valid_o pulses got %0d expected 1", $time, core_n);
      end
      assert (host_n == 1)
      else
      begin
         errors++;
         $display("ERROR t=%0t host_rsp_valid_o pulses got %0d expected 1", $time, host_n);
      end
      port_access(OWNER_CORE, make_req(OP_READ, 16'h0500, 8'h00, '0));
   endtask

   task automatic random_mix_test();
      fork
         for (int i = 0; i < 40; i++)
            port_access(OWNER_CORE, rand_req(OWNER_CORE));
         for (int i = 0; i < 40; i++)
            port_access(OWNER_HOST, rand_req(OWNER_HOST));
      join
   endtask

   initial
   begin
      seed             = 32'h1ca4c52e;
      errors           = 0;
      timeouts         = 0;
      arst_n_i         = 1'b0;
      core_req_valid_i = 1'b0;
      host_req_valid_i = 1'b0;
      core_req_i       = '0;
      host_req_i       = '0;
      boot_sel_i       = 2'b00;
      repeat (2) @(posedge ram_clk);
      arst_n_i <= 1'b1;
      reset_state_test();
      merge_and_lane_test();
      cross_port_test();
      random_mix_test();
      repeat (2) @(posedge ram_clk);
      $display("Checks done: errors=%0d timeouts=%0d", errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

endmodule

// File: boot_mem_top.f
source/boot_mem_pkg.sv
source/req_slot.sv
source/bram_arbiter.sv
source/wide_bram.sv
source/boot_mem_top.sv
tb/tb_boot_mem_top.sv

// File: run_sim.sh
#!/bin/sh
# Builds the boot RAM testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_boot_mem_top \
   -f boot_mem_top.f -o sim_boot_mem > build.log 2>&1 \
   && ./obj_dir/sim_boot_mem > sim.log 2>&1 \
   || { cat build.log sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }

cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1 || exit 0
